/* bist_pkg.sv */
package bist_pkg;

    // phase of the test sequencer, shared by the step interface and all blocks
    typedef enum logic [3:0] {
        PH_IDLE,
        PH_MB_WRITE,    // march write, one row per cycle
        PH_MB_READ,     // read back, compare lands one cycle later
        PH_MB_DRAIN,    // last compare of a pattern
        PH_SA_SHIFT,    // scan in broadcast vectors
        PH_SA_CAPTURE,  // functional capture, read row 0
        PH_SA_CHECK,    // row 0 compared against eNVM answer
        PH_COMPLETE,
        PH_FAIL
    } bist_phase_e;

    // default array geometry
    localparam int DEF_SYSTOLIC_SIZE = 8;   // lanes and accumulator rows
    localparam int DEF_WEIGHT_W      = 8;
    localparam int DEF_ACT_W         = 8;

    // pattern counts
    localparam int DEF_MB_PATTERNS   = 8;   // one per march background
    localparam int DEF_SA_PATTERNS   = 12;  // stored in eNVM

endpackage

/* bist_response_check.sv */
`timescale 1ns/1ps

module bist_response_check #(
    parameter int SYSTOLIC_SIZE = 8,
    parameter int PSUM_W        = 19
) (
    input  logic                            clk,
    input  logic                            rst_n,
    bist_step_if.chk                        step,
    input  logic [PSUM_W-1:0]               envm_answer,
    input  logic [PSUM_W-1:0]               mb_word,
    input  logic [SYSTOLIC_SIZE*PSUM_W-1:0] partial_sum_flat,
    output logic [SYSTOLIC_SIZE-1:0]        compared_results,
    output logic                            mismatch
);

    logic [PSUM_W-1:0] expected;
    logic              check_d;     // read data is on partial_sum_flat this cycle

    // expected value follows the step that issued the read
    always_ff @(posedge clk) begin
        if (step.phase == bist_pkg::PH_SA_SHIFT) begin
            expected <= envm_answer;
        end else if (step.check_en && step.phase == bist_pkg::PH_MB_READ) begin
            expected <= mb_word;
        end
    end

    // one cycle read latency of the accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            check_d <= 1'b0;
        end else begin
            check_d <= step.check_en;
        end
    end

    // per-lane compare, quiet outside compare cycles
    always_comb begin
        for (int i = 0; i < SYSTOLIC_SIZE; i++) begin
            compared_results[i] = check_d &&
                                  (partial_sum_flat[i*PSUM_W +: PSUM_W] != expected);
        end
    end

    assign mismatch = |compared_results;    // any faulty lane

endmodule

/* bist_sequencer.sv */
`timescale 1ns/1ps

module bist_sequencer #(
    parameter int SYSTOLIC_SIZE = 8,
    parameter int MB_PATTERNS   = 8,
    parameter int SA_PATTERNS   = 12,
    parameter int ROW_W         = 3,
    parameter int PAT_W         = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             test_mode,
    input  logic             bist_mode,     // 0 mbist, 1 stuck-at
    input  logic             mismatch,
    bist_step_if.seq         step,
    output logic             acc_wr_en,
    output logic             scan_en,
    output logic             diagnosis_start_en,
    output logic             detection_en,
    output logic             test_done,
    output logic             mbist_fail,
    output logic [ROW_W-1:0] acc_wr_addr,
    output logic [ROW_W-1:0] acc_rd_addr,
    output logic [PAT_W-1:0] test_counter
);

    bist_pkg::bist_phase_e phase;
    logic [PAT_W-1:0]      pattern;
    logic [ROW_W-1:0]      row;

    logic last_row;
    logic last_mb_pat;
    logic last_sa_pat;
    logic mb_phase;

    assign last_row    = (row == ROW_W'(SYSTOLIC_SIZE - 1));
    assign last_mb_pat = (pattern == PAT_W'(MB_PATTERNS - 1));
    assign last_sa_pat = (pattern == PAT_W'(SA_PATTERNS - 1));

    assign mb_phase = (phase == bist_pkg::PH_MB_WRITE) ||
                      (phase == bist_pkg::PH_MB_READ)  ||
                      (phase == bist_pkg::PH_MB_DRAIN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= bist_pkg::PH_IDLE;
            pattern <= '0;
            row     <= '0;
        end else if (mb_phase && mismatch) begin
            phase <= bist_pkg::PH_FAIL;     // freeze counters, stop writing
        end else begin
            case (phase)
                bist_pkg::PH_IDLE: begin
                    if (start && test_mode) begin
                        pattern <= '0;
                        row     <= '0;
                        phase   <= bist_mode ? bist_pkg::PH_SA_SHIFT : bist_pkg::PH_MB_WRITE;
                    end
                end

                bist_pkg::PH_MB_WRITE: begin
                    if (last_row) begin
                        row   <= '0;
                        phase <= bist_pkg::PH_MB_READ;
                    end else begin
                        row <= row + 1'b1;
                    end
                end

                bist_pkg::PH_MB_READ: begin
                    if (last_row) begin
                        row   <= '0;
                        phase <= bist_pkg::PH_MB_DRAIN;
                    end else begin
                        row <= row + 1'b1;
                    end
                end

                // last read still in flight here
                bist_pkg::PH_MB_DRAIN: begin
                    if (last_mb_pat) begin
                        phase <= bist_pkg::PH_COMPLETE;
                    end else begin
                        pattern <= pattern + 1'b1;
                        phase   <= bist_pkg::PH_MB_WRITE;
                    end
                end

                bist_pkg::PH_SA_SHIFT:   phase <= bist_pkg::PH_SA_CAPTURE;
                bist_pkg::PH_SA_CAPTURE: phase <= bist_pkg::PH_SA_CHECK;

                bist_pkg::PH_SA_CHECK: begin
                    if (last_sa_pat) begin
                        phase <= bist_pkg::PH_COMPLETE;
                    end else begin
                        pattern <= pattern + 1'b1;
                        phase   <= bist_pkg::PH_SA_SHIFT;
                    end
                end

                bist_pkg::PH_COMPLETE,
                bist_pkg::PH_FAIL: begin
                    if (!start) begin
                        phase <= bist_pkg::PH_IDLE;
                    end
                end

                default: phase <= bist_pkg::PH_IDLE;
            endcase
        end
    end

    // step seen by the vector and response sides
    assign step.phase       = phase;
    assign step.pattern_idx = pattern;
    assign step.row         = row;
    assign step.check_en    = (phase == bist_pkg::PH_MB_READ) ||
                              (phase == bist_pkg::PH_SA_CAPTURE);

    // strobes decoded straight from the phase
    assign acc_wr_en          = (phase == bist_pkg::PH_MB_WRITE);
    assign scan_en            = (phase == bist_pkg::PH_SA_SHIFT);
    assign diagnosis_start_en = (phase == bist_pkg::PH_SA_SHIFT)   ||
                                (phase == bist_pkg::PH_SA_CAPTURE) ||
                                (phase == bist_pkg::PH_SA_CHECK);
    assign detection_en       = (phase == bist_pkg::PH_SA_CHECK) && last_sa_pat;
    assign test_done          = (phase == bist_pkg::PH_COMPLETE) ||
                                (phase == bist_pkg::PH_FAIL);
    assign mbist_fail         = (phase == bist_pkg::PH_FAIL);

    assign acc_wr_addr  = row;
    assign acc_rd_addr  = (phase == bist_pkg::PH_SA_CAPTURE) ? '0 : row;  // logic bist reads row 0
    assign test_counter = pattern;  // eNVM pattern index

endmodule

/* bist_step_if.sv */
`timescale 1ns/1ps

interface bist_step_if #(
    parameter int ROW_W = 3,
    parameter int PAT_W = 4
);

    bist_pkg::bist_phase_e phase;
    logic [PAT_W-1:0]      pattern_idx;
    logic [ROW_W-1:0]      row;
    logic                  check_en;    // address on the read port needs a compare

    modport seq (
        output phase,
        output pattern_idx,
        output row,
        output check_en
    );

    // vector side only looks at the step
    modport gen (
        input phase,
        input pattern_idx,
        input row,
        input check_en
    );

    modport chk (
        input phase,
        input pattern_idx,
        input row,
        input check_en
    );

endinterface

/* bist_top.sv */
`timescale 1ns/1ps

module bist_top #(
    parameter int SYSTOLIC_SIZE = bist_pkg::DEF_SYSTOLIC_SIZE,
    parameter int WEIGHT_W      = bist_pkg::DEF_WEIGHT_W,
    parameter int ACT_W         = bist_pkg::DEF_ACT_W,
    parameter int PSUM_W        = WEIGHT_W + ACT_W + $clog2(SYSTOLIC_SIZE),
    parameter int MB_PATTERNS   = bist_pkg::DEF_MB_PATTERNS,
    parameter int SA_PATTERNS   = bist_pkg::DEF_SA_PATTERNS,
    localparam int ROW_W        = $clog2(SYSTOLIC_SIZE),
    localparam int PAT_W        = $clog2((MB_PATTERNS > SA_PATTERNS) ? MB_PATTERNS : SA_PATTERNS)
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic                              test_mode,
    input  logic                              bist_mode,
    input  logic [WEIGHT_W-1:0]               envm_weight,
    input  logic [ACT_W-1:0]                  envm_activation,
    input  logic [PSUM_W-1:0]                 envm_partial_sum_in,
    input  logic [PSUM_W-1:0]                 envm_answer,
    input  logic [SYSTOLIC_SIZE*PSUM_W-1:0]   partial_sum_flat,
    output logic [PAT_W-1:0]                  test_counter,
    output logic                              scan_en,
    output logic [SYSTOLIC_SIZE*WEIGHT_W-1:0] weight_in_test_flat,
    output logic [SYSTOLIC_SIZE*ACT_W-1:0]    activation_in_test_flat,
    output logic [SYSTOLIC_SIZE*PSUM_W-1:0]   partial_sum_test_flat,
    output logic                              diagnosis_start_en,
    output logic                              detection_en,
    output logic [SYSTOLIC_SIZE-1:0]          compared_results,
    output logic                              acc_wr_en,
    output logic [ROW_W-1:0]                  acc_wr_addr,
    output logic [SYSTOLIC_SIZE*PSUM_W-1:0]   acc_wr_data,
    output logic [ROW_W-1:0]                  acc_rd_addr,
    output logic                              test_done,
    output logic                              mbist_fail
);

    logic [PSUM_W-1:0] mb_word;     // mbist expected word
    logic              mismatch;

    bist_step_if #(.ROW_W(ROW_W), .PAT_W(PAT_W)) step_if ();

    bist_sequencer #(
        .SYSTOLIC_SIZE (SYSTOLIC_SIZE),
        .MB_PATTERNS   (MB_PATTERNS),
        .SA_PATTERNS   (SA_PATTERNS),
        .ROW_W         (ROW_W),
        .PAT_W         (PAT_W)
    ) u_sequencer (
        .clk                (clk),
        .rst_n              (rst_n),
        .start              (start),
        .test_mode          (test_mode),
        .bist_mode          (bist_mode),
        .mismatch           (mismatch),
        .step               (step_if.seq),
        .acc_wr_en          (acc_wr_en),
        .scan_en            (scan_en),
        .diagnosis_start_en (diagnosis_start_en),
        .detection_en       (detection_en),
        .test_done          (test_done),
        .mbist_fail         (mbist_fail),
        .acc_wr_addr        (acc_wr_addr),
        .acc_rd_addr        (acc_rd_addr),
        .test_counter       (test_counter)
    );

    bist_vector_gen #(
        .SYSTOLIC_SIZE (SYSTOLIC_SIZE),
        .WEIGHT_W      (WEIGHT_W),
        .ACT_W         (ACT_W),
        .PSUM_W        (PSUM_W)
    ) u_vector_gen (
        .step                    (step_if.gen),
        .envm_weight             (envm_weight),
        .envm_activation         (envm_activation),
        .envm_partial_sum_in     (envm_partial_sum_in),
        .weight_in_test_flat     (weight_in_test_flat),
        .activation_in_test_flat (activation_in_test_flat),
        .partial_sum_test_flat   (partial_sum_test_flat),
        .acc_wr_data             (acc_wr_data),
        .mb_word                 (mb_word)
    );

    bist_response_check #(
        .SYSTOLIC_SIZE (SYSTOLIC_SIZE),
        .PSUM_W        (PSUM_W)
    ) u_response_check (
        .clk              (clk),
        .rst_n            (rst_n),
        .step             (step_if.chk),
        .envm_answer      (envm_answer),
        .mb_word          (mb_word),
        .partial_sum_flat (partial_sum_flat),
        .compared_results (compared_results),
        .mismatch         (mismatch)
    );

endmodule

/* bist_top_chk.sv */
`timescale 1ns/1ps

module bist_top_chk #(
    parameter int SYSTOLIC_SIZE = 8
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     start,
    input logic                     acc_wr_en,
    input logic                     scan_en,
    input logic                     diagnosis_start_en,
    input logic                     detection_en,
    input logic                     test_done,
    input logic                     mbist_fail,
    input logic [SYSTOLIC_SIZE-1:0] compared_results
);

    // all strobes quiet in reset and on the first edge out of it
    reset_quiet: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> !(acc_wr_en || scan_en || test_done || mbist_fail ||
                                       detection_en) && compared_results == '0)
        else $error("strobes active during or right after reset");

    // one faulty lane seen in the compare cycle before fail
    fail_lane: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mbist_fail) |-> $onehot($past(compared_results)))
        else $error("fail entered without a single-lane mismatch");

    no_write_after_fail: assert property (@(posedge clk) disable iff (!rst_n)
        mbist_fail |=> !acc_wr_en)
        else $error("accumulator written after fail state");

    scan_single: assert property (@(posedge clk) disable iff (!rst_n)
        scan_en |=> !scan_en)
        else $error("scan_en high two cycles in a row");

    // shift, capture, check
    diag_window: assert property (@(posedge clk) disable iff (!rst_n)
        scan_en |-> diagnosis_start_en ##1 diagnosis_start_en ##1 diagnosis_start_en)
        else $error("diagnosis_start_en low inside a stuck-at pattern");

    detect_end: assert property (@(posedge clk) disable iff (!rst_n)
        detection_en |=> test_done && !mbist_fail)
        else $error("no clean completion after detection_en");

    done_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (test_done && start) |=> test_done)
        else $error("test_done dropped while start held");

    done_release: assert property (@(posedge clk) disable iff (!rst_n)
        (test_done && !start) |=> !test_done)
        else $error("test_done stayed high after start released");

endmodule

/* bist_vector_gen.sv */
`timescale 1ns/1ps

module bist_vector_gen #(
    parameter int SYSTOLIC_SIZE = 8,
    parameter int WEIGHT_W      = 8,
    parameter int ACT_W         = 8,
    parameter int PSUM_W        = 19
) (
    bist_step_if.gen                    step,
    input  logic [WEIGHT_W-1:0]         envm_weight,
    input  logic [ACT_W-1:0]            envm_activation,
    input  logic [PSUM_W-1:0]           envm_partial_sum_in,
    output logic [SYSTOLIC_SIZE*WEIGHT_W-1:0] weight_in_test_flat,
    output logic [SYSTOLIC_SIZE*ACT_W-1:0]    activation_in_test_flat,
    output logic [SYSTOLIC_SIZE*PSUM_W-1:0]   partial_sum_test_flat,
    output logic [SYSTOLIC_SIZE*PSUM_W-1:0]   acc_wr_data,
    output logic [PSUM_W-1:0]           mb_word
);

    logic [7:0] grp;    // one period of the background, lsb first

    // march backgrounds, all periodic within 8 bits
    always_comb begin
        case (step.pattern_idx[2:0])
            3'd0:    grp = 8'h00;   // solid 0
            3'd1:    grp = 8'hff;   // solid 1
            3'd2:    grp = 8'h55;   // checkerboard
            3'd3:    grp = 8'haa;
            3'd4:    grp = 8'h33;   // pairs
            3'd5:    grp = 8'hcc;
            3'd6:    grp = 8'h0f;   // nibbles
            default: grp = 8'hf0;
        endcase
    end

    // stretch the group across the full psum width
    always_comb begin
        for (int j = 0; j < PSUM_W; j++) begin
            mb_word[j] = grp[j % 8];
        end
    end

    assign acc_wr_data = {SYSTOLIC_SIZE{mb_word}};  // same word on every lane

    // stuck-at vectors: eNVM operands on every lane while scanning
    always_comb begin
        weight_in_test_flat     = '0;
        activation_in_test_flat = '0;
        partial_sum_test_flat   = '0;
        if (step.phase == bist_pkg::PH_SA_SHIFT) begin
            weight_in_test_flat     = {SYSTOLIC_SIZE{envm_weight}};
            activation_in_test_flat = {SYSTOLIC_SIZE{envm_activation}};
            partial_sum_test_flat   = {SYSTOLIC_SIZE{envm_partial_sum_in}};
        end
    end

endmodule

/* filelist.f */
bist_pkg.sv
bist_step_if.sv
bist_vector_gen.sv
bist_sequencer.sv
bist_response_check.sv
bist_top.sv
bist_top_chk.sv
tb_bist_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_bist_top
./obj_dir/Vtb_bist_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a pass report"
    exit 1
fi

/* tb_bist_top.sv */
`timescale 1ns/1ps

module tb_bist_top;

    localparam int SIZE   = bist_pkg::DEF_SYSTOLIC_SIZE;
    localparam int WW     = bist_pkg::DEF_WEIGHT_W;
    localparam int AW     = bist_pkg::DEF_ACT_W;
    localparam int PW     = WW + AW + $clog2(SIZE);
    localparam int FW     = SIZE * PW;
    localparam int MB_PAT = bist_pkg::DEF_MB_PATTERNS;
    localparam int SA_PAT = bist_pkg::DEF_SA_PATTERNS;
    localparam int ROW_W  = $clog2(SIZE);
    localparam int PAT_W  = $clog2((MB_PAT > SA_PAT) ? MB_PAT : SA_PAT);
    localparam int LIMIT  = 2000;  // cycles per wait

    logic             clk = 1'b0;
    logic             rst_n, start, test_mode, bist_mode;
    logic [WW-1:0]    envm_weight;
    logic [AW-1:0]    envm_activation;
    logic [PW-1:0]    envm_partial_sum_in, envm_answer;
    logic [FW-1:0]    partial_sum_flat = '0;
    logic [PAT_W-1:0] test_counter;
    logic [ROW_W-1:0] acc_wr_addr, acc_rd_addr;
    logic [SIZE*WW-1:0] weight_in_test_flat;
    logic [SIZE*AW-1:0] activation_in_test_flat;
    logic [FW-1:0]    partial_sum_test_flat, acc_wr_data;
    logic [SIZE-1:0]  compared_results;
    logic             scan_en, diagnosis_start_en, detection_en;
    logic             acc_wr_en, test_done, mbist_fail;

    // accumulator model state and stuck-at data per pattern
    logic [FW-1:0]    acc_mem [SIZE];
    logic [FW-1:0]    wr_word, fault_mask, sa_row;
    logic             fault_val;
    logic [ROW_W-1:0] fault_row;
    int               fault_lane;
    logic [WW-1:0]    sa_w [2**PAT_W];
    logic [AW-1:0]    sa_a [2**PAT_W];
    logic [PW-1:0]    sa_p [2**PAT_W];
    logic [PW-1:0]    sa_ans [2**PAT_W];
    int               sa_lane [2**PAT_W];  // -1 when the array answers correctly

    always #4 clk = ~clk;

    bist_top u_bist_top (.*);

    bind bist_top bist_top_chk #(.SYSTOLIC_SIZE(SYSTOLIC_SIZE)) u_chk (.*);

    // stuck cell on the write path
    always_comb begin
        wr_word = fault_val ? (acc_wr_data | fault_mask) : (acc_wr_data & ~fault_mask);
        if (acc_wr_addr != fault_row) begin
            wr_word = acc_wr_data;
        end
    end

    // array response sits in row 0 during stuck-at runs
    always @(posedge clk) begin
        if (acc_wr_en) begin
            acc_mem[acc_wr_addr] <= wr_word;
        end
        partial_sum_flat <= (bist_mode && acc_rd_addr == '0) ? sa_row :
                            acc_mem[acc_rd_addr];  // 1 cycle read
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // repeated group, read with its last written bit at bit 0
    function automatic logic [PW-1:0] march_word(input int p);
        logic [7:0]    grp;
        int            per;
        logic [PW-1:0] w;
        case (p)
            0:       grp = 8'b0;
            1:       grp = 8'b1;
            2:       grp = 8'b01;
            3:       grp = 8'b10;
            4:       grp = 8'b0011;
            5:       grp = 8'b1100;
            6:       grp = 8'b00001111;
            default: grp = 8'b11110000;
        endcase
        per = (p < 2) ? 1 : (p < 4) ? 2 : (p < 6) ? 4 : 8;
        for (int j = 0; j < PW; j++) begin
            w[j] = grp[3'(j % per)];
        end
        return w;
    endfunction

    task automatic run_mbist(input bit faulty);
        int              guard, cycles, writes;
        logic [SIZE-1:0] seen;
        @(negedge clk);
        bist_mode = 1'b0;
        test_mode = 1'b1;
        start     = 1'b1;
        guard     = 0;
        do begin
            @(posedge clk);
            guard++;
        end while (!acc_wr_en && guard < LIMIT);
        if (!acc_wr_en) abort_run("mbist run never started writing");
        cycles = 0;
        writes = 0;
        seen   = '0;
        while (!test_done && cycles < LIMIT) begin
            if (acc_wr_en) begin
                assert (acc_wr_addr == ROW_W'(writes % SIZE) &&
                        acc_wr_data == {SIZE{march_word(writes / SIZE)}})
                else abort_run($sformatf("ERR %0t: write %0d row %0d data %h", $time,
                                         writes, acc_wr_addr, acc_wr_data));
                writes++;
            end
            if (compared_results != '0) seen = compared_results;
            @(posedge clk);
            cycles++;
        end
        if (!test_done) abort_run("mbist run timed out waiting for test_done");
        assert (mbist_fail == faulty)
        else abort_run($sformatf("ERR %0t: mbist_fail %b after march", $time, mbist_fail));
        if (faulty) begin
            assert (seen == (SIZE'(1) << fault_lane))
            else abort_run($sformatf("ERR %0t: fail mask %b, lane %0d", $time, seen, fault_lane));
        end else begin
            assert (cycles == MB_PAT * (2 * SIZE + 1) && seen == '0)
            else abort_run($sformatf("ERR %0t: march took %0d cycles", $time, cycles));
        end
    endtask

    task automatic drive_stuck_at_inputs();
        logic [PAT_W-1:0] k;
        k = test_counter;
        envm_weight         = sa_w[k];
        envm_activation     = sa_a[k];
        envm_partial_sum_in = sa_p[k];
        envm_answer         = sa_ans[k];
        sa_row              = {SIZE{sa_ans[k]}};
        if (sa_lane[k] >= 0) begin
            sa_row = sa_row ^ (FW'(1) << (sa_lane[k] * PW + int'(k)));  // faulty PE output
        end
    endtask

    task automatic run_stuck_at();
        int              guard, scans, dets;
        logic            scan_d1, scan_d2, last_det;
        logic [SIZE-1:0] mask_d1, mask_d2;
        logic [PAT_W-1:0] idx;
        for (int k = 0; k < 2**PAT_W; k++) begin
            sa_w[k]    = WW'($urandom);
            sa_a[k]    = AW'($urandom);
            sa_p[k]    = PW'($urandom);
            sa_ans[k]  = PW'($urandom);
            sa_lane[k] = ($urandom_range(0, 2) == 0) ? int'($urandom_range(0, SIZE - 1)) : -1;
        end
        sa_lane[0]          = -1;
        sa_lane[SA_PAT - 1] = int'($urandom_range(0, SIZE - 1));
        {guard, scans, dets, scan_d1, scan_d2, last_det} = '0;
        {mask_d1, mask_d2} = '0;
        @(negedge clk);
        bist_mode = 1'b1;
        test_mode = 1'b1;
        start     = 1'b1;
        while (!test_done && guard < LIMIT) begin
            drive_stuck_at_inputs();
            @(posedge clk);
            guard++;
            if (scan_d2) begin
                assert (compared_results == mask_d2)
                else abort_run($sformatf("ERR %0t: compare %b, expected %b", $time,
                                         compared_results, mask_d2));
            end
            last_det = detection_en;
            if (detection_en) begin
                assert (scan_d2 && scans == SA_PAT && !test_done)
                else abort_run($sformatf("ERR %0t: detection_en after %0d scans", $time, scans));
                dets++;
            end
            scan_d2 = scan_d1;
            mask_d2 = mask_d1;
            scan_d1 = scan_en;
            if (scan_en) begin
                idx = PAT_W'(scans);
                assert (test_counter == idx && weight_in_test_flat == {SIZE{sa_w[idx]}} &&
                        activation_in_test_flat == {SIZE{sa_a[idx]}} &&
                        partial_sum_test_flat == {SIZE{sa_p[idx]}})
                else abort_run($sformatf("ERR %0t: scan vectors wrong, counter %0d", $time,
                                         test_counter));
                mask_d1 = (sa_lane[idx] < 0) ? '0 : (SIZE'(1) << sa_lane[idx]);
                scans++;
            end
            @(negedge clk);
        end
        if (!test_done) abort_run("stuck-at run timed out waiting for test_done");
        assert (dets == 1 && last_det && !mbist_fail)
        else abort_run($sformatf("ERR %0t: %0d detection pulses at the end", $time, dets));
    endtask

    // done holds with start, drops one cycle after start goes low
    task automatic leave_end_state();
        repeat (3) begin
            @(posedge clk);
            assert (test_done) else abort_run($sformatf("ERR %0t: test_done dropped", $time));
        end
        @(negedge clk);
        start = 1'b0;
        @(posedge clk);
        assert (test_done) else abort_run($sformatf("ERR %0t: test_done fell early", $time));
        @(posedge clk);
        assert (!test_done) else abort_run($sformatf("ERR %0t: test_done stuck high", $time));
    endtask

    initial begin
        void'($urandom(32'he56a));
        {rst_n, start, test_mode, bist_mode} = '0;
        {envm_weight, envm_activation, envm_partial_sum_in, envm_answer} = '0;
        {fault_mask, sa_row, fault_val, fault_row, fault_lane} = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        run_mbist(1'b0);
        leave_end_state();
        fault_row  = ROW_W'($urandom_range(0, SIZE - 1));
        fault_lane = int'($urandom_range(0, SIZE - 1));
        fault_val  = 1'($urandom_range(0, 1));
        fault_mask = FW'(1) << (fault_lane * PW + int'($urandom_range(0, PW - 1)));
        run_mbist(1'b1);
        leave_end_state();
        fault_mask = '0;
        run_stuck_at();
        leave_end_state();
        $display("TEST OK");
        $finish;
    end

endmodule
